//--- build.f
rvv_pkg.sv
rvv_vtype_unit.sv
rvv_vreg_file.sv
rvv_issue_ctrl.sv
rvv_lane.sv
rvv_writeback.sv
rvv_top.sv
tb_rvv.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass message in the output
verilator --binary --timing -j 0 -f build.f --top-module tb_rvv -o tb_rvv \
    && ./obj_dir/tb_rvv | tee /dev/stderr | grep -q "Test completed successfully" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

//--- rvv_issue_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module rvv_issue_ctrl import rvv_pkg::*; #(
    parameter int LANES = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req,
    output logic                        ack,
    input  rvv_op_e                     op,
    input  logic [REG_ADDR_W-1:0]       vd,
    input  logic [REG_ADDR_W-1:0]       vs1,
    input  logic [REG_ADDR_W-1:0]       vs2,
    input  logic [LANE_W-1:0]           scalar,
    input  logic [AVL_W-1:0]            vl_q,
    input  logic [2:0]                  sew_q,
    input  logic [2:0]                  lmul_q,
    input  logic                        vill_q,
    output logic                        setup_en,
    output logic [REG_ADDR_W-1:0]       ra_a,
    output logic [REG_ADDR_W-1:0]       ra_b,
    output logic [REG_ADDR_W-1:0]       ra_c,
    input  logic [LANES*LANE_W-1:0]     rd_a,
    input  logic [LANES*LANE_W-1:0]     rd_b,
    input  logic [LANES*LANE_W-1:0]     rd_c,
    output logic [LANES*LANE_W-1:0]     lane_a,
    output logic [LANES*LANE_W-1:0]     lane_b,
    output logic [LANES*LANE_W-1:0]     lane_old,
    output logic [LANES*LANE_W/8-1:0]   lane_en,
    output rvv_op_e                     lane_op,
    output logic [2:0]                  lane_sew,
    output logic [LANE_W-1:0]           lane_scalar,
    output logic                        issue_valid,
    output logic [2:0]                  issue_idx,
    input  logic                        group_done
);

    localparam int VLEN   = LANES * LANE_W;
    localparam int ELEMS8 = VLEN / 8;

    issue_state_e state;
    logic [2:0]   k;                      // Group member being read
    logic [3:0]   grp_size;
    logic         last_k;

    assign grp_size = 4'd1 << lmul_q;
    assign last_k   = ({1'b0, k} == grp_size - 4'd1);

    //////////////////// Handshake FSM
    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= IDLE;
            k     <= '0;
            ack   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    k <= '0;
                    if (req) begin
                        if (op == OP_VSETVL)
                            state <= SETUP;
                        else if (vill_q)
                            state <= ACK;     // Illegal vtype, no write
                        else
                            state <= READ;
                    end
                end
                SETUP: state <= ACK;
                READ: begin
                    if (last_k)
                        state <= DRAIN;
                    else
                        k <= k + 3'd1;
                end
                DRAIN: if (group_done) state <= ACK;
                ACK: begin
                    ack   <= 1'b1;
                    state <= RELEASE;
                end
                RELEASE: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign setup_en    = (state == SETUP);
    assign issue_valid = (state == READ);
    assign issue_idx   = k;

    //////////////////// Operand distribution
    assign ra_a = vs1 + REG_ADDR_W'(k);
    assign ra_b = vs2 + REG_ADDR_W'(k);
    assign ra_c = vd + REG_ADDR_W'(k);

    assign lane_a      = rd_a;
    assign lane_b      = rd_b;
    assign lane_old    = rd_c;
    assign lane_op     = op;
    assign lane_sew    = sew_q;
    assign lane_scalar = scalar;

    // A byte is enabled while its element index is below vl
    always_comb begin
        logic [AVL_W-1:0] idx;
        for (int j = 0; j < ELEMS8; j++) begin
            idx = AVL_W'(k) * AVL_W'(ELEMS8 >> sew_q) + AVL_W'(j >> sew_q);
            lane_en[j] = (idx < vl_q);
        end
    end

endmodule

`default_nettype wire

//--- rvv_lane.sv
`timescale 1ns/10ps
`default_nettype none

module rvv_lane import rvv_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  logic [LANE_W-1:0] a,          // vs1 slice
    input  logic [LANE_W-1:0] b,          // vs2 slice
    input  logic [LANE_W-1:0] old,        // Old vd slice
    input  logic [3:0]        en,
    input  rvv_op_e           op,
    input  logic [2:0]        sew,
    input  logic [LANE_W-1:0] scalar,
    output logic              out_valid,
    output logic [LANE_W-1:0] result
);

    logic [3:0]        elem_start;        // Byte opens an element
    logic [LANE_W-1:0] scl_rep;
    logic [LANE_W-1:0] add_rhs;
    logic [LANE_W-1:0] add_res;
    logic [LANE_W-1:0] sub_res;           // vs2 minus vs1
    logic [3:0]        ge_top;            // No borrow out of this byte
    logic [LANE_W-1:0] merged;

    always_comb begin
        case (sew)
            SEW_ENC_8: begin
                elem_start = 4'b1111;
                scl_rep    = {4{scalar[7:0]}};
            end
            SEW_ENC_16: begin
                elem_start = 4'b0101;
                scl_rep    = {2{scalar[15:0]}};
            end
            default: begin
                elem_start = 4'b0001;     // SEW_ENC_32
                scl_rep    = scalar;
            end
        endcase
    end

    assign add_rhs = (op == OP_VADD_VX) ? scl_rep : a;

    //////////////////// Byte carry chains
    // Carry restarts at each element border
    always_comb begin
        logic c_add;
        logic c_sub;
        c_add = 1'b0;
        c_sub = 1'b1;
        for (int i = 0; i < 4; i++) begin
            if (elem_start[i]) begin
                c_add = 1'b0;
                c_sub = 1'b1;
            end
            {c_add, add_res[8*i +: 8]} = {1'b0, b[8*i +: 8]} + {1'b0, add_rhs[8*i +: 8]}
                                         + 9'(c_add);
            {c_sub, sub_res[8*i +: 8]} = {1'b0, b[8*i +: 8]} + {1'b0, ~a[8*i +: 8]}
                                         + 9'(c_sub);
            ge_top[i] = c_sub;
        end
    end

    //////////////////// Op select and tail merge
    always_comb begin
        logic       ge;
        logic [7:0] va;
        logic [7:0] vb;
        logic [7:0] alu;
        for (int i = 0; i < 4; i++) begin
            va = a[8*i +: 8];
            vb = b[8*i +: 8];
            ge = (sew == SEW_ENC_8)  ? ge_top[i] :
                 (sew == SEW_ENC_16) ? ge_top[i | 1] : ge_top[3];   // Top byte of element
            case (op)
                OP_VADD, OP_VADD_VX: alu = add_res[8*i +: 8];
                OP_VSUB:  alu = sub_res[8*i +: 8];
                OP_VAND:  alu = va & vb;
                OP_VOR:   alu = va | vb;
                OP_VXOR:  alu = va ^ vb;
                OP_VMINU: alu = ge ? va : vb;
                OP_VMAXU: alu = ge ? vb : va;
                default:  alu = old[8*i +: 8];
            endcase
            merged[8*i +: 8] = en[i] ? alu : old[8*i +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (in_valid)
            result <= merged;
    end

endmodule

`default_nettype wire

//--- rvv_pkg.sv
`default_nettype none

package rvv_pkg;

    //////////////////// Widths
    localparam int LANE_W     = 32;       // Bits per lane
    localparam int AVL_W      = 9;        // Width of avl and vl
    localparam int REG_ADDR_W = 5;        // 32 vector registers

    //////////////////// vtype encodings
    localparam logic [2:0] SEW_ENC_8  = 3'd0;
    localparam logic [2:0] SEW_ENC_16 = 3'd1;
    localparam logic [2:0] SEW_ENC_32 = 3'd2;   // 3 to 7 reserved

    localparam logic [2:0] LMUL_ENC_1 = 3'd0;
    localparam logic [2:0] LMUL_ENC_2 = 3'd1;
    localparam logic [2:0] LMUL_ENC_4 = 3'd2;
    localparam logic [2:0] LMUL_ENC_8 = 3'd3;   // Fractional LMUL is reserved

    //////////////////// Opcodes and states
    typedef enum logic [3:0] {
        OP_VSETVL  = 4'd0,
        OP_VADD    = 4'd1,
        OP_VSUB    = 4'd2,
        OP_VAND    = 4'd3,
        OP_VOR     = 4'd4,
        OP_VXOR    = 4'd5,
        OP_VMINU   = 4'd6,
        OP_VMAXU   = 4'd7,
        OP_VADD_VX = 4'd8                     // vs2 plus scalar
    } rvv_op_e;

    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        SETUP   = 3'd1,
        READ    = 3'd2,
        DRAIN   = 3'd3,
        ACK     = 3'd4,
        RELEASE = 3'd5
    } issue_state_e;

endpackage

`default_nettype wire

//--- rvv_top.sv
`timescale 1ns/10ps
`default_nettype none

module rvv_top import rvv_pkg::*; #(
    parameter int LANES = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req,
    input  rvv_op_e                   op,
    input  logic [REG_ADDR_W-1:0]     vd,
    input  logic [REG_ADDR_W-1:0]     vs1,
    input  logic [REG_ADDR_W-1:0]     vs2,
    input  logic [LANE_W-1:0]         scalar,
    input  logic [AVL_W-1:0]          avl,
    input  logic [2:0]                sew_enc,
    input  logic [2:0]                lmul_enc,
    output logic                      ack,
    output logic [AVL_W-1:0]          vl,
    output logic                      vill,
    input  logic                      host_we,
    input  logic [REG_ADDR_W-1:0]     host_addr,
    input  logic [LANES*LANE_W-1:0]   host_wdata,
    input  logic [REG_ADDR_W-1:0]     host_raddr,
    output logic [LANES*LANE_W-1:0]   host_rdata
);

    localparam int VLEN = LANES * LANE_W;

    logic [2:0]            sew_q;
    logic [2:0]            lmul_q;
    logic                  setup_en;
    logic [REG_ADDR_W-1:0] ra_a, ra_b, ra_c;
    logic [VLEN-1:0]       rd_a, rd_b, rd_c;
    logic [VLEN-1:0]       lane_a, lane_b, lane_old;
    logic [VLEN/8-1:0]     lane_en;
    rvv_op_e               lane_op;
    logic [2:0]            lane_sew;
    logic [LANE_W-1:0]     lane_scalar;
    logic                  issue_valid;
    logic [2:0]            issue_idx;
    logic [LANES-1:0]      lane_vld;
    logic [VLEN-1:0]       lane_res;
    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [VLEN-1:0]       wb_data;
    logic                  group_done;

    rvv_vtype_unit #(.LANES(LANES)) vtype_inst (
        .clk(clk), .rst(rst), .setup_en(setup_en),
        .sew_enc(sew_enc), .lmul_enc(lmul_enc), .avl(avl),
        .vl_q(vl), .sew_q(sew_q), .lmul_q(lmul_q), .vill_q(vill)
    );

    rvv_vreg_file #(.LANES(LANES)) vreg_inst (
        .clk(clk), .rst(rst),
        .ra_a(ra_a), .ra_b(ra_b), .ra_c(ra_c),
        .rd_a(rd_a), .rd_b(rd_b), .rd_c(rd_c),
        .wb_we(wb_we), .wb_addr(wb_addr), .wb_data(wb_data),
        .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
        .host_raddr(host_raddr), .host_rdata(host_rdata)
    );

    rvv_issue_ctrl #(.LANES(LANES)) issue_inst (
        .clk(clk), .rst(rst), .req(req), .ack(ack),
        .op(op), .vd(vd), .vs1(vs1), .vs2(vs2), .scalar(scalar),
        .vl_q(vl), .sew_q(sew_q), .lmul_q(lmul_q), .vill_q(vill),
        .setup_en(setup_en), .ra_a(ra_a), .ra_b(ra_b), .ra_c(ra_c),
        .rd_a(rd_a), .rd_b(rd_b), .rd_c(rd_c),
        .lane_a(lane_a), .lane_b(lane_b), .lane_old(lane_old), .lane_en(lane_en),
        .lane_op(lane_op), .lane_sew(lane_sew), .lane_scalar(lane_scalar),
        .issue_valid(issue_valid), .issue_idx(issue_idx), .group_done(group_done)
    );

    //////////////////// Lanes
    for (genvar g = 0; g < LANES; g++) begin : g_lane
        rvv_lane lane_inst (
            .clk(clk), .rst(rst), .in_valid(issue_valid),
            .a(lane_a[LANE_W*g +: LANE_W]),
            .b(lane_b[LANE_W*g +: LANE_W]),
            .old(lane_old[LANE_W*g +: LANE_W]),
            .en(lane_en[4*g +: 4]),
            .op(lane_op), .sew(lane_sew), .scalar(lane_scalar),
            .out_valid(lane_vld[g]),
            .result(lane_res[LANE_W*g +: LANE_W])
        );
    end

    rvv_writeback #(.LANES(LANES)) wb_inst (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid), .issue_idx(issue_idx),
        .lane_valid(&lane_vld),           // Lanes run in lock step
        .lane_result(lane_res), .vd(vd), .lmul_q(lmul_q),
        .wb_we(wb_we), .wb_addr(wb_addr), .wb_data(wb_data),
        .group_done(group_done)
    );

endmodule

`default_nettype wire

//--- rvv_vreg_file.sv
`timescale 1ns/10ps
`default_nettype none

module rvv_vreg_file import rvv_pkg::*; #(
    parameter int LANES = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [REG_ADDR_W-1:0]     ra_a,
    input  logic [REG_ADDR_W-1:0]     ra_b,
    input  logic [REG_ADDR_W-1:0]     ra_c,
    output logic [LANES*LANE_W-1:0]   rd_a,
    output logic [LANES*LANE_W-1:0]   rd_b,
    output logic [LANES*LANE_W-1:0]   rd_c,
    input  logic                      wb_we,
    input  logic [REG_ADDR_W-1:0]     wb_addr,
    input  logic [LANES*LANE_W-1:0]   wb_data,
    input  logic                      host_we,
    input  logic [REG_ADDR_W-1:0]     host_addr,
    input  logic [LANES*LANE_W-1:0]   host_wdata,
    input  logic [REG_ADDR_W-1:0]     host_raddr,
    output logic [LANES*LANE_W-1:0]   host_rdata
);

    localparam int VLEN  = LANES * LANE_W;
    localparam int NREGS = 1 << REG_ADDR_W;

    logic [VLEN-1:0] regs [NREGS];

    //////////////////// Write port
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we) begin
            regs[wb_addr] <= wb_data;     // Writeback wins over host
        end else if (host_we) begin
            regs[host_addr] <= host_wdata;
        end
    end

    //////////////////// Read ports
    assign rd_a       = regs[ra_a];       // vs1 group member
    assign rd_b       = regs[ra_b];       // vs2 group member
    assign rd_c       = regs[ra_c];       // Old vd for tail merge
    assign host_rdata = regs[host_raddr];

endmodule

`default_nettype wire

//--- rvv_vtype_unit.sv
`timescale 1ns/10ps
`default_nettype none

module rvv_vtype_unit import rvv_pkg::*; #(
    parameter int LANES = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             setup_en,
    input  logic [2:0]       sew_enc,
    input  logic [2:0]       lmul_enc,
    input  logic [AVL_W-1:0] avl,
    output logic [AVL_W-1:0] vl_q,
    output logic [2:0]       sew_q,
    output logic [2:0]       lmul_q,
    output logic             vill_q
);

    localparam int VLEN   = LANES * LANE_W;
    localparam int ELEMS8 = VLEN / 8;     // Elements per register at SEW 8

    logic [AVL_W:0] elems_per_reg;
    logic [AVL_W:0] vlmax;
    logic           sew_ok;
    logic           lmul_ok;

    //////////////////// Decode
    always_comb begin
        sew_ok = 1'b1;
        case (sew_enc)
            SEW_ENC_8:  elems_per_reg = (AVL_W+1)'(ELEMS8);
            SEW_ENC_16: elems_per_reg = (AVL_W+1)'(ELEMS8 / 2);
            SEW_ENC_32: elems_per_reg = (AVL_W+1)'(ELEMS8 / 4);
            default: begin
                elems_per_reg = '0;
                sew_ok        = 1'b0;     // Reserved SEW
            end
        endcase
    end

    always_comb begin
        lmul_ok = 1'b1;
        case (lmul_enc)
            LMUL_ENC_1: vlmax = elems_per_reg;
            LMUL_ENC_2: vlmax = elems_per_reg << 1;
            LMUL_ENC_4: vlmax = elems_per_reg << 2;
            LMUL_ENC_8: vlmax = elems_per_reg << 3;
            default: begin
                vlmax   = '0;
                lmul_ok = 1'b0;           // Fractional or reserved
            end
        endcase
    end

    //////////////////// vl and vtype registers
    always_ff @(posedge clk) begin
        if (!rst) begin
            vl_q   <= '0;
            sew_q  <= '0;
            lmul_q <= '0;
            vill_q <= 1'b0;
        end else if (setup_en) begin
            if (sew_ok && lmul_ok) begin
                vl_q   <= ({1'b0, avl} < vlmax) ? avl : vlmax[AVL_W-1:0];
                sew_q  <= sew_enc;
                lmul_q <= lmul_enc;
                vill_q <= 1'b0;
            end else begin
                vl_q   <= '0;             // vill clears vl and vtype
                sew_q  <= '0;
                lmul_q <= '0;
                vill_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rvv_writeback.sv
`timescale 1ns/10ps
`default_nettype none

module rvv_writeback import rvv_pkg::*; #(
    parameter int LANES = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_valid,
    input  logic [2:0]                issue_idx,
    input  logic                      lane_valid,
    input  logic [LANES*LANE_W-1:0]   lane_result,
    input  logic [REG_ADDR_W-1:0]     vd,
    input  logic [2:0]                lmul_q,
    output logic                      wb_we,
    output logic [REG_ADDR_W-1:0]     wb_addr,
    output logic [LANES*LANE_W-1:0]   wb_data,
    output logic                      group_done
);

    logic [2:0] idx_fifo [2];             // Member index across lane stage
    logic       wr_ptr;
    logic       rd_ptr;
    logic [2:0] cnt;                      // Members written so far
    logic [3:0] grp_size;
    logic       last;

    assign grp_size = 4'd1 << lmul_q;
    assign last     = ({1'b0, cnt} == grp_size - 4'd1);

    always_ff @(posedge clk) begin
        if (issue_valid)
            idx_fifo[wr_ptr] <= issue_idx;
    end

    //////////////////// Control
    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr     <= 1'b0;
            rd_ptr     <= 1'b0;
            cnt        <= '0;
            wb_we      <= 1'b0;
            group_done <= 1'b0;
        end else begin
            if (issue_valid)
                wr_ptr <= ~wr_ptr;
            if (lane_valid) begin
                rd_ptr <= ~rd_ptr;
                cnt    <= last ? '0 : cnt + 3'd1;
            end
            wb_we      <= lane_valid;
            group_done <= lane_valid && last;   // Pulses with the final write
        end
    end

    always_ff @(posedge clk) begin
        if (lane_valid) begin
            wb_addr <= vd + REG_ADDR_W'(idx_fifo[rd_ptr]);
            wb_data <= lane_result;
        end
    end

endmodule

`default_nettype wire

//--- tb_rvv.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rvv import rvv_pkg::*; ();

    localparam int LANES   = 4;
    localparam int VLEN    = LANES * LANE_W;
    localparam int TIMEOUT = 60;          // Cycles per handshake phase

    logic                  clk;
    logic                  rst;
    logic                  req;
    rvv_op_e               op;
    logic [REG_ADDR_W-1:0] vd;
    logic [REG_ADDR_W-1:0] vs1;
    logic [REG_ADDR_W-1:0] vs2;
    logic [LANE_W-1:0]     scalar;
    logic [AVL_W-1:0]      avl;
    logic [2:0]            sew_enc;
    logic [2:0]            lmul_enc;
    logic                  ack;
    logic [AVL_W-1:0]      vl;
    logic                  vill;
    logic                  host_we;
    logic [REG_ADDR_W-1:0] host_addr;
    logic [VLEN-1:0]       host_wdata;
    logic [REG_ADDR_W-1:0] host_raddr;
    logic [VLEN-1:0]       host_rdata;

    logic [VLEN-1:0] ref_regs [32];       // Reference register file
    int              ref_vl;
    int              ref_sew_bits;
    int              ref_lmul;
    logic            ref_vill;
    int              errors;
    int              checks;
    int              hs_errors = 0;       // Counted by the handshake monitor
    logic            ack_prev  = 1'b0;
    logic            req_prev  = 1'b0;
    string           test_name;

    rvv_top #(.LANES(LANES)) rvv_top_inst (
        .clk(clk), .rst(rst), .req(req), .op(op),
        .vd(vd), .vs1(vs1), .vs2(vs2), .scalar(scalar),
        .avl(avl), .sew_enc(sew_enc), .lmul_enc(lmul_enc),
        .ack(ack), .vl(vl), .vill(vill),
        .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
        .host_raddr(host_raddr), .host_rdata(host_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ack may only rise while req is held and only fall once req is gone
    always @(negedge clk) begin
        if (rst) begin
            if (ack && !ack_prev && !req_prev) begin
                hs_errors++;
                $display("** Handshake error: ack rose while req was low");
            end
            if (!ack && ack_prev && req_prev) begin
                hs_errors++;
                $display("** Handshake error: ack fell while req was still high");
            end
        end
        ack_prev = ack;
        req_prev = req;
    end

    //////////////////// Reference model
    function automatic logic [31:0] elem_result(input rvv_op_e f_op, input logic [31:0] ea,
            input logic [31:0] eb, input logic [31:0] es, input logic [31:0] mask);
        logic [31:0] r;
        case (f_op)
            OP_VADD:    r = eb + ea;
            OP_VSUB:    r = eb - ea;      // vs2 minus vs1
            OP_VAND:    r = eb & ea;
            OP_VOR:     r = eb | ea;
            OP_VXOR:    r = eb ^ ea;
            OP_VMINU:   r = (ea < eb) ? ea : eb;
            OP_VMAXU:   r = (ea > eb) ? ea : eb;
            OP_VADD_VX: r = eb + es;
            default:    r = 32'd0;
        endcase
        return r & mask;                  // Carry stops at the element border
    endfunction

    task automatic model_exec(input rvv_op_e f_op, input int f_vd, input int f_vs1,
            input int f_vs2, input logic [31:0] f_scalar, input int f_avl,
            input int f_sew, input int f_lmul);
        int              elems;
        int              vlmax;
        int              sh;
        logic [VLEN-1:0] dst;
        logic [31:0]     mask;
        logic [31:0]     ea;
        logic [31:0]     eb;
        logic [31:0]     res;
        if (f_op == OP_VSETVL) begin
            if (f_sew > 2 || f_lmul > 3) begin
                ref_vill = 1'b1;          // Reserved vtype
                ref_vl   = 0;
            end else begin
                ref_vill     = 1'b0;
                ref_sew_bits = 8 << f_sew;
                ref_lmul     = 1 << f_lmul;
                vlmax        = VLEN / ref_sew_bits * ref_lmul;
                ref_vl       = (f_avl < vlmax) ? f_avl : vlmax;
            end
        end else if (!ref_vill) begin
            elems = VLEN / ref_sew_bits;
            mask  = (ref_sew_bits == 32) ? 32'hffff_ffff : ((32'd1 << ref_sew_bits) - 32'd1);
            for (int k = 0; k < ref_lmul; k++) begin
                dst = ref_regs[f_vd + k];
                for (int e = 0; e < elems; e++) begin
                    sh = e * ref_sew_bits;
                    if (k * elems + e < ref_vl) begin   // Tail stays undisturbed
                        ea  = 32'(ref_regs[f_vs1 + k] >> sh) & mask;
                        eb  = 32'(ref_regs[f_vs2 + k] >> sh) & mask;
                        res = elem_result(f_op, ea, eb, f_scalar & mask, mask);
                        dst = (dst & ~(VLEN'(mask) << sh)) | (VLEN'(res) << sh);
                    end
                end
                ref_regs[f_vd + k] = dst;
            end
        end
    endtask

    //////////////////// Bus helpers
    function automatic logic [VLEN-1:0] rand_vec();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic load_reg(input int addr, input logic [VLEN-1:0] data);
        host_we    = 1'b1;
        host_addr  = REG_ADDR_W'(addr);
        host_wdata = data;
        @(posedge clk);
        #1;
        host_we       = 1'b0;
        ref_regs[addr] = data;
    endtask

    task automatic wait_ack(input logic level, output logic ok);
        int cnt;
        cnt = 0;
        while (ack !== level && cnt < TIMEOUT) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        ok = (ack === level);
    endtask

    task automatic issue_instr(input rvv_op_e i_op, input int i_vd, input int i_vs1,
            input int i_vs2, input logic [31:0] i_scalar, input int i_avl,
            input int i_sew, input int i_lmul);
        logic ok;
        model_exec(i_op, i_vd, i_vs1, i_vs2, i_scalar, i_avl, i_sew, i_lmul);
        op       = i_op;
        vd       = REG_ADDR_W'(i_vd);
        vs1      = REG_ADDR_W'(i_vs1);
        vs2      = REG_ADDR_W'(i_vs2);
        scalar   = i_scalar;
        avl      = AVL_W'(i_avl);
        sew_enc  = 3'(i_sew);
        lmul_enc = 3'(i_lmul);
        req      = 1'b1;
        wait_ack(1'b1, ok);
        if (!ok) begin
            errors++;
            $display("** Timeout in %s: ack never rose for %s", test_name, i_op.name());
        end
    endtask

    task automatic release_req();
        logic ok;
        req = 1'b0;
        wait_ack(1'b0, ok);
        if (!ok) begin
            errors++;
            $display("** Timeout in %s: ack stayed high after req fell", test_name);
        end
    endtask

    task automatic run_instr(input rvv_op_e i_op, input int i_vd, input int i_vs1,
            input int i_vs2, input logic [31:0] i_scalar, input int i_avl,
            input int i_sew, input int i_lmul);
        issue_instr(i_op, i_vd, i_vs1, i_vs2, i_scalar, i_avl, i_sew, i_lmul);
        release_req();
    endtask

    //////////////////// Checks
    task automatic check_reg(input int addr);
        host_raddr = REG_ADDR_W'(addr);
        @(posedge clk);
        #1;
        checks++;
        if (host_rdata !== ref_regs[addr]) begin
            errors++;
            $display("** Error %s: v%0d expected %h actual %h", test_name, addr,
                     ref_regs[addr], host_rdata);
        end
    endtask

    task automatic check_regs();
        for (int r = 0; r < 32; r++) begin
            check_reg(r);
        end
    endtask

    task automatic check_status();
        checks++;
        if (vl !== AVL_W'(ref_vl) || vill !== ref_vill) begin
            errors++;
            $display("** Error %s: vl/vill expected %0d/%0b actual %0d/%0b", test_name,
                     ref_vl, ref_vill, vl, vill);
        end
    endtask

    //////////////////// Tests
    task automatic handshake_test();
        int op_i;
        int hold;
        test_name = "handshake_test";
        checks++;
        if (ack !== 1'b0) begin
            errors++;
            $display("** Error %s: ack expected 0 actual %b", test_name, ack);
        end
        for (int r = 0; r < 32; r++) begin
            load_reg(r, rand_vec());
        end
        for (int n = 0; n < 24; n++) begin
            op_i = int'($urandom_range(0, 8));  // Back to back with no idle gap
            issue_instr(rvv_op_e'(op_i), 16, 0, 8, $urandom, int'($urandom_range(0, 140)),
                        int'($urandom_range(0, 2)), int'($urandom_range(0, 3)));
            hold = int'($urandom_range(1, 3));  // req stays up after ack rises
            repeat (hold) begin
                @(posedge clk);
                #1;
            end
            release_req();
        end
        check_regs();
    endtask

    task automatic vsetvl_test();
        int avl_list [7] = '{0, 1, 5, 16, 33, 200, 511};
        test_name = "vsetvl_test";
        for (int s = 0; s < 3; s++) begin
            for (int l = 0; l < 4; l++) begin
                for (int a = 0; a < 7; a++) begin
                    run_instr(OP_VSETVL, 0, 0, 0, 32'd0, avl_list[a], s, l);
                    check_status();
                end
            end
        end
    endtask

    task automatic vill_test();
        test_name = "vill_test";
        load_reg(1, rand_vec());
        load_reg(2, rand_vec());
        load_reg(10, rand_vec());
        run_instr(OP_VSETVL, 0, 0, 0, 32'd0, 20, 3, 0);    // Reserved SEW
        check_status();
        run_instr(OP_VADD, 10, 1, 2, 32'd0, 0, 0, 0);
        check_reg(10);
        run_instr(OP_VSETVL, 0, 0, 0, 32'd0, 20, 0, 5);    // Fractional LMUL
        check_status();
        run_instr(OP_VSUB, 10, 1, 2, 32'd0, 0, 0, 0);
        check_reg(10);
        run_instr(OP_VSETVL, 0, 0, 0, 32'd0, 20, 7, 6);
        check_status();
    endtask

    task automatic alu_ops_test();
        rvv_op_e         ops [8] = '{OP_VADD, OP_VSUB, OP_VAND, OP_VOR,
                                     OP_VXOR, OP_VMINU, OP_VMAXU, OP_VADD_VX};
        logic [VLEN-1:0] vec_a;
        logic [VLEN-1:0] vec_b;
        test_name = "alu_ops_test";
        for (int s = 0; s < 3; s++) begin
            run_instr(OP_VSETVL, 0, 0, 0, 32'd0, 511, s, 0);   // Full vl at LMUL 1
            check_status();
            for (int i = 0; i < 8; i++) begin
                vec_a = rand_vec();
                vec_b = rand_vec();
                vec_b[VLEN-1 -: 32] = vec_a[VLEN-1 -: 32];    // Some equal elements
                load_reg(1, vec_a);
                load_reg(2, vec_b);
                load_reg(3, rand_vec());
                run_instr(ops[i], 3, 1, 2, $urandom, 0, 0, 0);
                check_reg(3);
            end
        end
    endtask

    task automatic tail_test();
        int avl_list [3] = '{5, 3, 2};
        test_name = "tail_test";
        for (int s = 0; s < 3; s++) begin
            run_instr(OP_VSETVL, 0, 0, 0, 32'd0, avl_list[s], s, 0);
            check_status();
            load_reg(1, rand_vec());
            load_reg(2, rand_vec());
            load_reg(3, rand_vec());
            run_instr(OP_VADD, 3, 1, 2, 32'd0, 0, 0, 0);
            check_reg(3);
            run_instr(OP_VXOR, 3, 2, 1, 32'd0, 0, 0, 0);
            check_reg(3);
        end
        run_instr(OP_VSETVL, 0, 0, 0, 32'd0, 11, 1, 1);   // Tail inside second register
        check_status();
        load_reg(4, rand_vec());
        load_reg(5, rand_vec());
        run_instr(OP_VMAXU, 4, 6, 8, 32'd0, 0, 0, 0);
        check_regs();
    endtask

    task automatic group_test();
        test_name = "group_test";
        for (int r = 0; r < 32; r++) begin
            load_reg(r, rand_vec());
        end
        run_instr(OP_VSETVL, 0, 0, 0, 32'd0, 10, 2, 2);   // LMUL 4 with vl ending mid group
        check_status();
        run_instr(OP_VADD, 16, 0, 8, 32'd0, 0, 0, 0);
        check_regs();
        run_instr(OP_VSETVL, 0, 0, 0, 32'd0, 100, 0, 3);  // LMUL 8
        check_status();
        run_instr(OP_VSUB, 16, 0, 8, 32'd0, 0, 0, 0);
        check_regs();
        run_instr(OP_VSETVL, 0, 0, 0, 32'd0, 45, 1, 3);
        check_status();
        run_instr(OP_VADD_VX, 16, 0, 8, $urandom, 0, 0, 0);
        check_regs();
    endtask

    //////////////////// Main sequence
    initial begin
        rst        = 1'b0;
        req        = 1'b0;
        op         = OP_VSETVL;
        vd         = '0;
        vs1        = '0;
        vs2        = '0;
        scalar     = '0;
        avl        = '0;
        sew_enc    = '0;
        lmul_enc   = '0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        host_raddr = '0;
        errors       = 0;
        checks       = 0;
        ref_vl       = 0;
        ref_sew_bits = 8;
        ref_lmul     = 1;
        ref_vill     = 1'b0;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;             // Reset clears the register file
        end
        void'($urandom(48));
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;

        handshake_test();
        vsetvl_test();
        vill_test();
        alu_ops_test();
        tail_test();
        group_test();

        $display("Checks: %0d, errors: %0d, handshake errors: %0d", checks, errors, hs_errors);
        if (errors == 0 && hs_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
